// File: all.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_stage_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memory.sv
hw/rv_writeback.sv
hw/rv_core_top.sv
sim/rv_core_properties.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator, verdict from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f all.f -o rv_core_sim \
    > build.log 2>&1 &&
./obj_dir/rv_core_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Finished with errors" sim.log &&
{ echo "simulation FAILED"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

// File: sim/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_tb;

    localparam int PROG_LEN    = 200;
    localparam int WATCHDOG_NS = (PROG_LEN + 20) * 2 * 100;

    logic               clk;
    logic               rst_n;
    logic               halt;
    rv_pkg::xlen_t      imem_addr;
    rv_pkg::instr_t     imem_data;
    logic               dmem_read_wrn;
    rv_pkg::dmem_addr_t dmem_addr;
    rv_pkg::xlen_t      dmem_wdata;
    rv_pkg::xlen_t      dmem_rdata = '0;
    logic               instr_retired;
    logic               breakpoint_fired;
    logic               finish_exec;

    int chk_errors;
    int store_checks;
    int retire_checks;
    int store_left;
    int retire_left;
    int tb_errors = 0;
    int halt_cycles = 0;

    rv_pkg::instr_t prog [PROG_LEN];
    logic           prog_ready = 1'b0;
    rv_pkg::xlen_t  dmem [rv_pkg::dmem_addr_t];
    logic [31:0]    lfsr;
    int             gen_idx;
    logic [4:0]     recent [3];       // rd of the last three slots
    logic [31:0]    written;          // registers holding a known value

    rv_core_top rv_core_top_i (.*);

    rv_core_checker checker_i (.*, .error_count(chk_errors));

    // ********************
    // clock and watchdog
    // ********************
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: ECALL did not retire within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // ********************
    // program generator
    // ********************
    task emit(input rv_pkg::instr_t w, input logic [4:0] rd);
        prog[gen_idx] = w;
        gen_idx++;
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = rd;
        written[rd] = 1'b1;
    endtask

    // readable source, else x0
    function logic [4:0] pick_src();
        logic [31:0] v;
        logic [4:0]  r;
        r = 5'd0;
        for (int t = 0; t < 4; t++) begin
            v = take_bits(5);
            if (r == 5'd0 && written[v[4:0]] && v[4:0] != recent[0]
                && v[4:0] != recent[1] && v[4:0] != recent[2]) r = v[4:0];
        end
        return r;
    endfunction

    function logic [4:0] pick_dst();
        logic [31:0] v;
        v = take_bits(5);
        return (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
    endfunction

    // base register and offset for a data access
    task pick_addr(output logic [4:0] base, output logic [11:0] imm);
        logic [31:0] v;
        v = take_bits(13);
        base = v[12] ? 5'd0 : pick_src();   // x0 base keeps hits in a small window
        imm  = v[12] ? {6'd0, v[5:0]} : v[11:0];
    endtask

    task build_program();
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [11:0] imm;
        logic [2:0]  f3;
        gen_idx = 0;
        written = 32'd1;
        recent  = '{5'd0, 5'd0, 5'd0};
        for (int i = 0; i < PROG_LEN; i++) prog[i] = '0;
        repeat (4) emit('0, 5'd0);          // pc counts through bubbles first
        while (gen_idx < PROG_LEN - 6) begin
            v = take_bits(4);
            if (v == 32'd0) begin
                emit('0, 5'd0);
            end else if (v == 32'd1) begin
                emit({12'd1, 13'd0, `RV_OP_SYSTEM}, 5'd0);            // ebreak
            end else if (v < 32'd9) begin
                rd  = pick_dst();
                rs  = pick_src();
                v   = take_bits(14);
                f3  = (v[1:0] == 2'd0) ? `RV_F3_ADD_SUB : (v[1:0] == 2'd1) ? `RV_F3_XOR :
                      (v[1:0] == 2'd2) ? `RV_F3_OR : `RV_F3_AND;
                if (v[2]) emit({v[13:2], rs, f3, rd, `RV_OP_IMM}, rd);
                else emit({1'b0, v[3] && f3 == 3'd0, 5'd0, pick_src(), rs, f3, rd,
                           `RV_OP_REG}, rd);
            end else if (v < 32'd12) begin
                rd = pick_dst();
                pick_addr(rs, imm);
                v  = take_bits(3) % 32'd5;
                f3 = (v == 0) ? `RV_F3_B : (v == 1) ? `RV_F3_H : (v == 2) ? `RV_F3_W :
                     (v == 3) ? `RV_F3_BU : `RV_F3_HU;
                emit({imm, rs, f3, rd, `RV_OP_LOAD}, rd);
                repeat (3) emit('0, 5'd0);  // distance before the value is read
                v   = take_bits(6);
                imm = {6'd0, v[5:0]};
                emit({imm[11:5], rd, 5'd0, `RV_F3_W, imm[4:0], `RV_OP_STORE}, 5'd0);
            end else begin
                rd = pick_src();
                pick_addr(rs, imm);
                v  = take_bits(2) % 32'd3;
                f3 = (v == 0) ? `RV_F3_B : (v == 1) ? `RV_F3_H : `RV_F3_W;
                emit({imm[11:5], rd, rs, f3, imm[4:0], `RV_OP_STORE}, 5'd0);
            end
        end
        emit({25'd0, `RV_OP_SYSTEM}, 5'd0);                        // ecall ends it
    endtask

    // ********************
    // memory models
    // ********************
    function automatic rv_pkg::instr_t fetch_word(input rv_pkg::xlen_t a);
        rv_pkg::xlen_t idx;
        idx = a >> 2;
        return (idx < PROG_LEN) ? prog[idx[7:0]] : '0;   // zeros past the end
    endfunction

    always_comb imem_data = prog_ready ? fetch_word(imem_addr) : '0;

    always @(posedge clk) begin
        if (rst_n && !halt && !dmem_read_wrn) dmem[dmem_addr] = dmem_wdata;
    end

    always @(negedge clk) begin     // address settled since the rising edge
        dmem_rdata = dmem.exists(dmem_addr) ? dmem[dmem_addr]
                                            : {16'd0, dmem_addr} * 32'h0001_0003;
    end

    task expect_value(input string name, input rv_pkg::xlen_t expected,
                      input rv_pkg::xlen_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    // ********************
    // test sequence
    // ********************
    initial begin
        rst_n = 1'b0;
        halt  = 1'b0;
        lfsr  = 32'hfa4b_e228;
        build_program();
        prog_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        expect_value("imem_addr", '0, imem_addr);
        expect_value("dmem_read_wrn", 32'd1, {31'd0, dmem_read_wrn});
        expect_value("instr_retired", '0, {31'd0, instr_retired});
        expect_value("breakpoint_fired", '0, {31'd0, breakpoint_fired});
        expect_value("finish_exec", '0, {31'd0, finish_exec});
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        $display("test reset_state: done, %0d errors", tb_errors);
        while (!finish_exec) begin
            @(posedge clk);
            #1;
            halt = (take_bits(4) == 32'd0);   // about one cycle in sixteen
            if (halt) halt_cycles++;
        end
        halt = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        $display("test program_run: ECALL retired, %0d halt cycles, %0d errors",
                 halt_cycles, chk_errors);
        if (store_left != 0 || retire_left != 0) begin
            $display("ERROR: %0d stores and %0d retirements expected but never seen",
                     store_left, retire_left);
            tb_errors++;
        end
        $display("test drain: done, %0d errors", tb_errors + chk_errors);
        $display("summary: 3 tests, %0d stores, %0d retirements checked, %0d errors",
                 store_checks, retire_checks, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim/rv_core_checker.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt,
    input  rv_pkg::xlen_t      imem_addr,
    input  rv_pkg::instr_t     imem_data,
    input  logic               dmem_read_wrn,
    input  rv_pkg::dmem_addr_t dmem_addr,
    input  rv_pkg::xlen_t      dmem_wdata,
    input  logic               instr_retired,
    input  logic               breakpoint_fired,
    input  logic               finish_exec,
    output int                 error_count,
    output int                 store_checks,
    output int                 retire_checks,
    output int                 store_left,     // expectations not yet seen
    output int                 retire_left
);

    rv_pkg::xlen_t regs [32];                  // architectural model
    rv_pkg::xlen_t mem [rv_pkg::dmem_addr_t];
    logic [47:0]   store_q [$];                // {addr, data}
    logic [1:0]    retire_q [$];               // {brk, fin}
    int            errors = 0;
    int            n_store = 0;
    int            n_retire = 0;
    logic          prev_valid = 1'b0;
    logic          prev_halt = 1'b0;
    rv_pkg::xlen_t prev_pc = '0;

    assign error_count   = errors;
    assign store_checks  = n_store;
    assign retire_checks = n_retire;

    task automatic report_mismatch(input string name, input rv_pkg::xlen_t expected,
                                   input rv_pkg::xlen_t actual);
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    // unwritten words hold a pattern of their address
    function automatic rv_pkg::xlen_t mem_default(input rv_pkg::dmem_addr_t a);
        return {16'd0, a} * 32'h0001_0003;
    endfunction

    // ********************
    // reference model
    // ********************
    function void reference_execute(input rv_pkg::instr_t w);
        logic [6:0]         op;
        logic [2:0]         f3;
        logic [4:0]         rd;
        rv_pkg::xlen_t      a;
        rv_pkg::xlen_t      b;
        rv_pkg::xlen_t      imm_i;
        rv_pkg::xlen_t      imm_s;
        rv_pkg::xlen_t      y;
        rv_pkg::xlen_t      raw;
        rv_pkg::dmem_addr_t addr;
        op    = w[6:0];
        f3    = w[14:12];
        rd    = w[11:7];
        a     = (w[19:15] == 5'd0) ? '0 : regs[w[19:15]];
        b     = (w[24:20] == 5'd0) ? '0 : regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        if (w != '0) begin
            if (op == `RV_OP_REG || op == `RV_OP_IMM) begin
                if (op == `RV_OP_IMM) begin
                    b = imm_i;
                end
                case (f3)
                    `RV_F3_ADD_SUB: y = (op == `RV_OP_REG && w[30]) ? a - b : a + b;
                    `RV_F3_XOR:     y = a ^ b;
                    `RV_F3_OR:      y = a | b;
                    default:        y = a & b;
                endcase
                if (rd != 5'd0) regs[rd] = y;
            end else if (op == `RV_OP_LOAD) begin
                y    = a + imm_i;
                addr = y[15:0];                           // bus keeps 16 bits
                raw  = mem.exists(addr) ? mem[addr] : mem_default(addr);
                case (f3)
                    `RV_F3_B:  y = {{24{raw[7]}}, raw[7:0]};
                    `RV_F3_H:  y = {{16{raw[15]}}, raw[15:0]};
                    `RV_F3_BU: y = {24'd0, raw[7:0]};
                    `RV_F3_HU: y = {16'd0, raw[15:0]};
                    default:   y = raw;
                endcase
                if (rd != 5'd0) regs[rd] = y;
            end else if (op == `RV_OP_STORE) begin
                y    = a + imm_s;
                addr = y[15:0];
                case (f3)
                    `RV_F3_B: raw = {{24{b[7]}}, b[7:0]};    // sign-extended on the bus
                    `RV_F3_H: raw = {{16{b[15]}}, b[15:0]};
                    default:  raw = b;
                endcase
                mem[addr] = raw;
                store_q.push_back({addr, raw});
            end
            retire_q.push_back({w == 32'h0010_0073, w == 32'h0000_0073});
        end
    endfunction

    // ********************
    // compare on each edge
    // ********************
    always @(posedge clk) begin
        logic [47:0]   exp_store;
        logic [1:0]    exp_retire;
        rv_pkg::xlen_t exp_pc;
        if (rst_n) begin
            // pc from 0 in steps of 4 and frozen by halt
            exp_pc = !prev_valid ? '0 : (prev_halt ? prev_pc : prev_pc + `RV_PC_STEP);
            if (imem_addr !== exp_pc) report_mismatch("imem_addr", exp_pc, imem_addr);
            prev_valid = 1'b1;
            prev_pc    = exp_pc;
            prev_halt  = halt;
            if (!halt) begin
                if (!dmem_read_wrn) begin
                    if (store_q.size() == 0) begin
                        $display("ERROR at %0t: unexpected store to %h", $time, dmem_addr);
                        errors++;
                    end else begin
                        exp_store = store_q.pop_front();
                        n_store++;
                        if (dmem_addr !== exp_store[47:32])
                            report_mismatch("dmem_addr", {16'd0, exp_store[47:32]},
                                            {16'd0, dmem_addr});
                        if (dmem_wdata !== exp_store[31:0])
                            report_mismatch("dmem_wdata", exp_store[31:0], dmem_wdata);
                    end
                end
                if (instr_retired) begin
                    if (retire_q.size() == 0) begin
                        $display("ERROR at %0t: retirement with nothing in flight", $time);
                        errors++;
                    end else begin
                        exp_retire = retire_q.pop_front();
                        n_retire++;
                        if (breakpoint_fired !== exp_retire[1])
                            report_mismatch("breakpoint_fired", {31'd0, exp_retire[1]},
                                            {31'd0, breakpoint_fired});
                        if (finish_exec !== exp_retire[0])
                            report_mismatch("finish_exec", {31'd0, exp_retire[0]},
                                            {31'd0, finish_exec});
                    end
                end else if (breakpoint_fired || finish_exec) begin
                    $display("ERROR at %0t: retire flag high without instr_retired", $time);
                    errors++;
                end
                reference_execute(imem_data);    // same word the ir takes now
            end
        end
        store_left  = store_q.size();
        retire_left = retire_q.size();
    end

endmodule

// File: sim/rv_core_properties.sv
`timescale 1ns/1ns

module rv_core_properties (
    input logic               clk,
    input logic               rst_n,
    input logic               halt,
    input logic               dmem_read_wrn,
    input rv_pkg::dmem_addr_t dmem_addr,
    input rv_pkg::xlen_t      dmem_wdata,
    input rv_pkg::xlen_t      imem_addr,
    input logic               instr_retired,
    input logic               breakpoint_fired,
    input logic               finish_exec
);

    // ********************
    // bus and retire rules
    // ********************
    store_held_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
        (halt && !dmem_read_wrn) |=> $stable(dmem_addr))
        else $error("store address moved across a halted cycle");

    // ecall and ebreak never share a retirement
    finish_not_with_break: assert property (@(posedge clk) disable iff (!rst_n)
        !(finish_exec && breakpoint_fired))
        else $error("finish_exec and breakpoint_fired high together");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!instr_retired && !breakpoint_fired && !finish_exec
                    && dmem_read_wrn && dmem_addr == '0 && dmem_wdata == '0
                    && imem_addr == '0))
        else $error("core outputs active during reset");

endmodule

bind rv_core_top rv_core_properties rv_core_properties_i (.*);

// File: hw/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt,              // freezes every stage
    output rv_pkg::xlen_t      imem_addr,
    input  rv_pkg::instr_t     imem_data,
    output logic               dmem_read_wrn,
    output rv_pkg::dmem_addr_t dmem_addr,
    output rv_pkg::xlen_t      dmem_wdata,
    input  rv_pkg::xlen_t      dmem_rdata,
    output logic               instr_retired,
    output logic               breakpoint_fired,
    output logic               finish_exec
);

    rv_pkg::instr_t    instr;        // ir, fetch -> decode
    rv_pkg::xlen_t     store_data;   // execute -> memory
    logic              rf_we;        // write-back -> register file
    rv_pkg::reg_addr_t rf_waddr;
    rv_pkg::xlen_t     rf_wdata;

    // stage bundles
    id_ex_if id_ex_i ();
    stage_if ex_mem_i ();
    stage_if mem_wb_i ();

    // ********************
    // stage chain
    // ********************
    rv_fetch rv_fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .instr     (instr)
    );

    rv_decode rv_decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .halt     (halt),
        .instr    (instr),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .id_ex    (id_ex_i.src)
    );

    rv_execute rv_execute_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .halt           (halt),
        .id_ex          (id_ex_i.dst),
        .ex_mem         (ex_mem_i.src),
        .store_data_out (store_data)
    );

    rv_memory rv_memory_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .halt          (halt),
        .ex_mem        (ex_mem_i.dst),
        .store_data    (store_data),
        .dmem_read_wrn (dmem_read_wrn),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_rdata    (dmem_rdata),
        .mem_wb        (mem_wb_i.src)
    );

    rv_writeback rv_writeback_i (
        .mem_wb           (mem_wb_i.dst),
        .rf_we            (rf_we),
        .rf_waddr         (rf_waddr),
        .rf_wdata         (rf_wdata),
        .instr_retired    (instr_retired),
        .breakpoint_fired (breakpoint_fired),
        .finish_exec      (finish_exec)
    );

endmodule

// File: hw/rv_writeback.sv
`timescale 1ns/1ns

module rv_writeback (
    stage_if.dst              mem_wb,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_waddr,
    output rv_pkg::xlen_t     rf_wdata,
    output logic              instr_retired,
    output logic              breakpoint_fired,
    output logic              finish_exec
);

    rv_pkg::xlen_t load_ext;
    rv_pkg::xlen_t wb_data;

    // ********************
    // load extension
    // ********************
    always_comb begin
        case (mem_wb.width)
            rv_pkg::w_half:   load_ext = {{16{mem_wb.result[15]}}, mem_wb.result[15:0]};
            rv_pkg::w_half_u: load_ext = {16'd0, mem_wb.result[15:0]};
            rv_pkg::w_byte:   load_ext = {{24{mem_wb.result[7]}}, mem_wb.result[7:0]};
            rv_pkg::w_byte_u: load_ext = {24'd0, mem_wb.result[7:0]};
            default:          load_ext = mem_wb.result;   // lw
        endcase
    end

    // alu results pass untouched
    assign wb_data = (mem_wb.mem_op == rv_pkg::mem_load) ? load_ext : mem_wb.result;

    // register write port, quiet unless wb_en
    assign rf_we    = mem_wb.valid && mem_wb.wb_en;
    assign rf_waddr = rf_we ? mem_wb.rd : '0;
    assign rf_wdata = rf_we ? wb_data : '0;

    // retire flags
    assign instr_retired    = mem_wb.valid;
    assign breakpoint_fired = mem_wb.valid && mem_wb.brk;
    assign finish_exec      = mem_wb.valid && mem_wb.fin;

endmodule

// File: hw/rv_memory.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_memory (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt,
    stage_if.dst               ex_mem,
    input  rv_pkg::xlen_t      store_data,
    output logic               dmem_read_wrn,   // low for a store
    output rv_pkg::dmem_addr_t dmem_addr,
    output rv_pkg::xlen_t      dmem_wdata,
    input  rv_pkg::xlen_t      dmem_rdata,
    stage_if.src               mem_wb
);

    logic          is_store;
    logic          is_access;
    rv_pkg::xlen_t store_ext;

    assign is_store  = (ex_mem.mem_op == rv_pkg::mem_store);
    assign is_access = (ex_mem.mem_op != rv_pkg::mem_none);

    // ********************
    // data bus drive
    // ********************
    // half and byte go out sign-extended, no byte enables
    always_comb begin
        case (ex_mem.width)
            rv_pkg::w_half, rv_pkg::w_half_u: store_ext = {{16{store_data[15]}}, store_data[15:0]};
            rv_pkg::w_byte, rv_pkg::w_byte_u: store_ext = {{24{store_data[7]}}, store_data[7:0]};
            default:                          store_ext = store_data;
        endcase
    end

    assign dmem_read_wrn = !is_store;
    assign dmem_addr     = is_access ? ex_mem.result[`RV_DMEM_ADDR_W-1:0] : '0;
    assign dmem_wdata    = is_store ? store_ext : '0;   // idle bus is zero

    // ********************
    // memory/write-back register
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb.valid  <= 1'b0;
            mem_wb.wb_en  <= 1'b0;
            mem_wb.mem_op <= rv_pkg::mem_none;
            mem_wb.width  <= rv_pkg::w_word;
            mem_wb.brk    <= 1'b0;
            mem_wb.fin    <= 1'b0;
        end else if (!halt) begin
            mem_wb.valid  <= ex_mem.valid;
            mem_wb.wb_en  <= ex_mem.wb_en;
            mem_wb.mem_op <= ex_mem.mem_op;
            mem_wb.width  <= ex_mem.width;
            mem_wb.brk    <= ex_mem.brk;
            mem_wb.fin    <= ex_mem.fin;
        end
    end

    always_ff @(posedge clk) begin
        if (!halt) begin
            mem_wb.rd     <= ex_mem.rd;
            mem_wb.result <= (ex_mem.mem_op == rv_pkg::mem_load) ? dmem_rdata   // raw word
                                                                 : ex_mem.result;
        end
    end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          halt,
    id_ex_if.dst          id_ex,
    stage_if.src          ex_mem,
    output rv_pkg::xlen_t store_data_out   // raw rs2, aligned with ex_mem
);

    rv_pkg::xlen_t alu_y;

    // ********************
    // alu
    // ********************
    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::alu_add: alu_y = id_ex.opnd_a + id_ex.opnd_b;   // wraps at 32 bits
            rv_pkg::alu_sub: alu_y = id_ex.opnd_a - id_ex.opnd_b;
            rv_pkg::alu_and: alu_y = id_ex.opnd_a & id_ex.opnd_b;
            rv_pkg::alu_or:  alu_y = id_ex.opnd_a | id_ex.opnd_b;
            rv_pkg::alu_xor: alu_y = id_ex.opnd_a ^ id_ex.opnd_b;
            default:         alu_y = '0;
        endcase
    end

    // ********************
    // execute/memory register
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.wb_en  <= 1'b0;
            ex_mem.mem_op <= rv_pkg::mem_none;
            ex_mem.width  <= rv_pkg::w_word;
            ex_mem.brk    <= 1'b0;
            ex_mem.fin    <= 1'b0;
        end else if (!halt) begin
            ex_mem.valid  <= id_ex.valid;
            ex_mem.wb_en  <= id_ex.wb_en;
            ex_mem.mem_op <= id_ex.mem_op;
            ex_mem.width  <= id_ex.width;
            ex_mem.brk    <= id_ex.brk;
            ex_mem.fin    <= id_ex.fin;
        end
    end

    always_ff @(posedge clk) begin
        if (!halt) begin
            ex_mem.rd      <= id_ex.rd;
            ex_mem.result  <= alu_y;              // data address for loads/stores
            store_data_out <= id_ex.store_data;
        end
    end

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              halt,
    input  rv_pkg::instr_t    instr,     // from the ir
    input  logic              rf_we,     // write port, from write-back
    input  rv_pkg::reg_addr_t rf_waddr,
    input  rv_pkg::xlen_t     rf_wdata,
    id_ex_if.src              id_ex
);

    // instruction fields
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::xlen_t     imm_i;
    rv_pkg::xlen_t     imm_s;

    // register file
    rv_pkg::xlen_t     regs [2**`RV_REG_ADDR_W];
    rv_pkg::xlen_t     rs1_data;
    rv_pkg::xlen_t     rs2_data;

    // decoded control, before the stage register
    logic              is_reg;
    logic              is_imm;
    logic              is_load;
    logic              is_store;
    logic              is_system;
    rv_pkg::alu_op_e   alu_op_d;
    rv_pkg::mem_op_e   mem_op_d;
    rv_pkg::width_e    width_d;

    // ********************
    // field split
    // ********************
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};              // sign-extended
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // split store imm

    assign is_reg    = (opcode == `RV_OP_REG);
    assign is_imm    = (opcode == `RV_OP_IMM);
    assign is_load   = (opcode == `RV_OP_LOAD);
    assign is_store  = (opcode == `RV_OP_STORE);
    assign is_system = (opcode == `RV_OP_SYSTEM);

    always_comb begin
        alu_op_d = rv_pkg::alu_add;   // loads and stores compute rs1 + imm
        if (is_reg || is_imm) begin
            case (funct3)
                `RV_F3_ADD_SUB: alu_op_d = (is_reg && funct7[5]) ? rv_pkg::alu_sub
                                                                  : rv_pkg::alu_add;
                `RV_F3_XOR:     alu_op_d = rv_pkg::alu_xor;
                `RV_F3_OR:      alu_op_d = rv_pkg::alu_or;
                `RV_F3_AND:     alu_op_d = rv_pkg::alu_and;
                default:        alu_op_d = rv_pkg::alu_add;   // unsupported, harmless
            endcase
        end
    end

    always_comb begin
        case (funct3)
            `RV_F3_B:  width_d = rv_pkg::w_byte;
            `RV_F3_H:  width_d = rv_pkg::w_half;
            `RV_F3_BU: width_d = rv_pkg::w_byte_u;
            `RV_F3_HU: width_d = rv_pkg::w_half_u;
            default:   width_d = rv_pkg::w_word;   // lw / sw
        endcase
    end

    assign mem_op_d = is_load  ? rv_pkg::mem_load  :
                      is_store ? rv_pkg::mem_store : rv_pkg::mem_none;

    // ********************
    // register file
    // ********************
    always_ff @(posedge clk) begin
        if (!halt && rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // no write-through, software keeps its distance
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // ********************
    // decode/execute register
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid  <= 1'b0;
            id_ex.wb_en  <= 1'b0;
            id_ex.mem_op <= rv_pkg::mem_none;
            id_ex.alu_op <= rv_pkg::alu_add;
            id_ex.width  <= rv_pkg::w_word;
            id_ex.brk    <= 1'b0;
            id_ex.fin    <= 1'b0;
        end else if (!halt) begin
            id_ex.valid  <= (instr != '0);                              // bubble check
            id_ex.wb_en  <= (is_reg || is_imm || is_load) && (rd != '0);
            id_ex.mem_op <= mem_op_d;
            id_ex.alu_op <= alu_op_d;
            id_ex.width  <= width_d;
            id_ex.brk    <= is_system && (funct3 == 3'b000) && (imm_i == 32'd1);
            id_ex.fin    <= is_system && (funct3 == 3'b000) && (imm_i == '0);
        end
    end

    // operands and rd
    always_ff @(posedge clk) begin
        if (!halt) begin
            id_ex.rd         <= rd;
            id_ex.opnd_a     <= rs1_data;
            id_ex.opnd_b     <= is_reg ? rs2_data : (is_store ? imm_s : imm_i);
            id_ex.store_data <= rs2_data;
        end
    end

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_fetch (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           halt,        // freezes pc and ir
    input  rv_pkg::instr_t imem_data,   // same-cycle answer from imem
    output rv_pkg::xlen_t  imem_addr,
    output rv_pkg::instr_t instr        // instruction register
);

    rv_pkg::xlen_t pc;

    // ********************
    // program counter
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!halt) begin
            pc <= pc + `RV_PC_STEP;   // straight line, no branches
        end
    end

    assign imem_addr = pc;

    // instruction register, zero word stays a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;              // start with bubbles
        end else if (!halt) begin
            instr <= imem_data;
        end
    end

endmodule

// File: hw/rv_stage_if.sv
`timescale 1ns/1ns

// decode -> execute bundle
interface id_ex_if;
    logic              valid;       // nonzero instruction in stage
    rv_pkg::reg_addr_t rd;
    logic              wb_en;       // writes rd at write-back
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::xlen_t     opnd_a;      // rs1
    rv_pkg::xlen_t     opnd_b;      // rs2 or immediate
    rv_pkg::xlen_t     store_data;  // raw rs2 for stores
    rv_pkg::mem_op_e   mem_op;
    rv_pkg::width_e    width;
    logic              brk;         // ebreak
    logic              fin;         // ecall

    modport src (output valid, rd, wb_en, alu_op, opnd_a, opnd_b, store_data,
                        mem_op, width, brk, fin);
    modport dst (input  valid, rd, wb_en, alu_op, opnd_a, opnd_b, store_data,
                        mem_op, width, brk, fin);
endinterface

// execute -> memory and memory -> write-back
interface stage_if;
    logic              valid;
    rv_pkg::reg_addr_t rd;
    logic              wb_en;
    rv_pkg::xlen_t     result;      // alu result, or load data after memory
    rv_pkg::mem_op_e   mem_op;
    rv_pkg::width_e    width;
    logic              brk;
    logic              fin;

    modport src (output valid, rd, wb_en, result, mem_op, width, brk, fin);
    modport dst (input  valid, rd, wb_en, result, mem_op, width, brk, fin);
endinterface

// File: hw/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    // vectors with a meaning
    typedef logic [`RV_XLEN-1:0]        xlen_t;       // data word
    typedef logic [`RV_XLEN-1:0]        instr_t;      // raw instruction, zero is a bubble
    typedef logic [`RV_REG_ADDR_W-1:0]  reg_addr_t;   // register index
    typedef logic [`RV_DMEM_ADDR_W-1:0] dmem_addr_t;  // data memory address

    // alu function
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    // memory access kind
    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    // access width and signedness
    typedef enum logic [2:0] {
        w_word,
        w_half,
        w_half_u,
        w_byte,
        w_byte_u
    } width_e;

endpackage

// File: hw/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ********************
// widths
// ********************
`define RV_XLEN        32       // data word
`define RV_REG_ADDR_W  5        // 32 registers
`define RV_DMEM_ADDR_W 16       // data bus address
`define RV_PC_STEP     32'd4    // one word per instruction

// ********************
// opcodes
// ********************
`define RV_OP_REG      7'b011_0011
`define RV_OP_IMM      7'b001_0011
`define RV_OP_LOAD     7'b000_0011
`define RV_OP_STORE    7'b010_0011
`define RV_OP_SYSTEM   7'b111_0011   // ecall / ebreak

// funct3, alu group
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_XOR      3'b100
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111
// funct3, load/store width
`define RV_F3_B        3'b000
`define RV_F3_H        3'b001
`define RV_F3_W        3'b010
`define RV_F3_BU       3'b100
`define RV_F3_HU       3'b101

`endif
